//--- list.f
+incdir+verilog
verilog/htable_pkg.sv
verilog/htable_upd_if.sv
verilog/htable_hash_stage.sv
verilog/htable_update_queue.sv
verilog/htable_insert_engine.sv
verilog/htable_bank.sv
verilog/htable_lookup.sv
verilog/htable_top.sv
tb/htable_assert.sv
tb/htable_tb.sv

//--- tb/htable_tb.sv
`timescale 1ns/1ns

`include "htable_defs.svh"

module htable_tb
    import htable_pkg::*;
();

    localparam int NUM     = `HTABLE_NUM_TABLES;
    localparam int HW      = `HTABLE_HASH_WID;
    localparam int BUCKETS = 1 << HW;
    localparam int POOL    = 14;
    localparam int N_MIX   = 200;
    // Updates sent over all tests: 1 + 2 + 8 + 8 + 4 + random mix
    localparam int NUM_UPDATES    = 23 + N_MIX;
    localparam int TIMEOUT_CYCLES = 40 * NUM_UPDATES + 2000;
    localparam logic [31:0] SEED  = 32'hc11ada5a;

    logic   clk;
    logic   rst_n;
    logic   upd_valid;
    logic   upd_ready;
    key_t   upd_key;
    value_t upd_value;
    logic   upd_insert;
    logic   query_valid;
    key_t   query_key;
    logic   result_valid;
    logic   result_found;
    value_t result_value;
    cnt_t   cnt_update;
    cnt_t   cnt_insert_ok;
    cnt_t   cnt_insert_fail;
    cnt_t   cnt_delete_ok;
    cnt_t   cnt_delete_fail;
    cnt_t   cnt_active;

    int n_checks = 0;
    int n_errors = 0;
    int cycles   = 0;

    // Reference model, key map plus bank occupancy
    value_t ref_table [key_t];
    logic   ref_valid [NUM][BUCKETS] = '{default: 1'b0};
    key_t   ref_key   [NUM][BUCKETS];
    cnt_t   exp_update   = '0;
    cnt_t   exp_ins_ok   = '0;
    cnt_t   exp_ins_fail = '0;
    cnt_t   exp_del_ok   = '0;
    cnt_t   exp_del_fail = '0;
    cnt_t   exp_active   = '0;

    // Expected results in query order, {found, value}
    logic [`HTABLE_VALUE_WID:0] exp_q [$];
    string                      name_q [$];

    htable_top uut (
        .clk, .rst_n, .upd_valid, .upd_ready, .upd_key, .upd_value, .upd_insert,
        .query_valid, .query_key, .result_valid, .result_found, .result_value,
        .cnt_update, .cnt_insert_ok, .cnt_insert_fail, .cnt_delete_ok,
        .cnt_delete_fail, .cnt_active
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic logic [`HTABLE_VALUE_WID:0] expected_lookup(input key_t key);
        if (ref_table.exists(key)) begin
            return {1'b1, ref_table[key]};
        end
        return '0;
    endfunction

    // Bank b indexes with key bits 4b through 4b+3
    task automatic model_update(input key_t key, input value_t value, input logic ins);
        int    hit_bank;
        int    free_bank;
        int    sel;
        hash_t idx;
        hit_bank  = -1;
        free_bank = -1;
        for (int b = NUM - 1; b >= 0; b--) begin
            idx = key[b*HW +: HW];
            if (ref_valid[b][idx] && (ref_key[b][idx] == key)) hit_bank = b;
            if (!ref_valid[b][idx]) free_bank = b;
        end
        exp_update++;
        if (ins) begin
            if ((hit_bank >= 0) || (free_bank >= 0)) begin
                sel = (hit_bank >= 0) ? hit_bank : free_bank;
                idx = key[sel*HW +: HW];
                ref_valid[sel][idx] = 1'b1;
                ref_key[sel][idx]   = key;
                ref_table[key]      = value;
                exp_ins_ok++;
                if (hit_bank < 0) exp_active++;
            end else begin
                exp_ins_fail++;
            end
        end else if (hit_bank >= 0) begin
            idx = key[hit_bank*HW +: HW];
            ref_valid[hit_bank][idx] = 1'b0;
            ref_table.delete(key);
            exp_del_ok++;
            exp_active--;
        end else begin
            exp_del_fail++;
        end
    endtask

    // ======================================================================
    // Checks and stimulus
    // ======================================================================

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_counters(input string name);
        check({name, " cnt_update"}, exp_update, cnt_update);
        check({name, " cnt_insert_ok"}, exp_ins_ok, cnt_insert_ok);
        check({name, " cnt_insert_fail"}, exp_ins_fail, cnt_insert_fail);
        check({name, " cnt_delete_ok"}, exp_del_ok, cnt_delete_ok);
        check({name, " cnt_delete_fail"}, exp_del_fail, cnt_delete_fail);
        check({name, " cnt_active"}, exp_active, cnt_active);
    endtask

    always @(negedge clk) begin : compare
        logic [`HTABLE_VALUE_WID:0] exp;
        string                      name;
        if (rst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("Lookup result arrived with no query outstanding at %0t", $time);
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                check({name, " found"}, exp[`HTABLE_VALUE_WID], result_found);
                check({name, " value"}, exp[`HTABLE_VALUE_WID-1:0], result_value);
            end
        end
    end

    // Called and returns on a falling edge
    task automatic send_update(input key_t key, input value_t value, input logic ins);
        upd_valid  = 1'b1;
        upd_key    = key;
        upd_value  = value;
        upd_insert = ins;
        while (!upd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        upd_valid = 1'b0;
        model_update(key, value, ins);
    endtask

    task automatic lookup(input key_t key, input string name);
        query_valid = 1'b1;
        query_key   = key;
        exp_q.push_back(expected_lookup(key));
        name_q.push_back(name);
        @(negedge clk);
        query_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Engine done once every accepted update is counted
    task automatic wait_drain();
        while ((cnt_insert_ok + cnt_insert_fail + cnt_delete_ok + cnt_delete_fail)
               != cnt_update) begin
            @(negedge clk);
        end
    endtask

    initial begin : main
        key_t   key_a;
        key_t   burst_keys [8];
        key_t   same_key;
        key_t   coll_keys [4];
        key_t   pool [POOL];
        cnt_t   act_start;
        cnt_t   ins_before;
        cnt_t   act_before;
        cnt_t   fail_before;
        logic   ins;
        int     n_look;
        int     assert_fail;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        upd_valid   = 1'b0;
        upd_key     = '0;
        upd_value   = '0;
        upd_insert  = 1'b0;
        query_valid = 1'b0;
        query_key   = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(2);

        // Insert then lookup
        act_start = exp_active;
        key_a = $urandom();
        key_a[3:0] = 4'h9;
        send_update(key_a, value_t'($urandom()), 1'b1);
        wait_drain();
        lookup(key_a, "insert_lookup");
        check("insert_lookup insert ok", 1, cnt_insert_ok);
        check("insert_lookup active", 1, cnt_active);
        check("insert_lookup updates", 1, cnt_update);
        check_counters("insert_lookup");

        // Delete twice
        send_update(key_a, '0, 1'b0);
        wait_drain();
        lookup(key_a, "delete_twice");
        check("delete_twice delete ok", 1, cnt_delete_ok);
        send_update(key_a, '0, 1'b0);
        wait_drain();
        check("delete_twice delete fail", 1, cnt_delete_fail);
        check("delete_twice active", act_start, cnt_active);
        check_counters("delete_twice");

        // Burst of distinct keys, bank 0 buckets 0 to 7
        for (int i = 0; i < 8; i++) begin
            burst_keys[i] = $urandom();
            burst_keys[i][3:0] = 4'(i);
        end
        for (int i = 0; i < 8; i++) begin
            send_update(burst_keys[i], value_t'($urandom()), 1'b1);
        end
        // One cycle for the last update to reach the queue
        idle_cycles(1);
        for (int i = 0; i < 8; i++) begin
            lookup(burst_keys[i], "burst_pending");
        end
        wait_drain();
        for (int i = 0; i < 8; i++) begin
            lookup(burst_keys[i], "burst_drained");
        end
        check_counters("burst");

        // Same key eight times, newest value wins
        ins_before = exp_ins_ok;
        act_before = exp_active;
        same_key = $urandom();
        same_key[3:0] = 4'h8;
        for (int i = 0; i < 8; i++) begin
            send_update(same_key, value_t'($urandom()), 1'b1);
        end
        idle_cycles(1);
        lookup(same_key, "same_key_pending");
        wait_drain();
        lookup(same_key, "same_key_drained");
        check("same_key insert ok", ins_before + 8, cnt_insert_ok);
        check("same_key active", act_before + 1, cnt_active);
        check_counters("same_key");

        // Four keys on the same three buckets
        ins_before  = exp_ins_ok;
        fail_before = exp_ins_fail;
        for (int i = 0; i < 4; i++) begin
            coll_keys[i] = $urandom();
            coll_keys[i][13:12] = 2'(i);
            coll_keys[i][11:0]  = 12'hA5F;
        end
        for (int i = 0; i < 4; i++) begin
            send_update(coll_keys[i], value_t'($urandom()), 1'b1);
        end
        wait_drain();
        for (int i = 0; i < 4; i++) begin
            lookup(coll_keys[i], "collision");
        end
        check("collision insert ok", ins_before + 3, cnt_insert_ok);
        check("collision insert fail", fail_before + 1, cnt_insert_fail);
        check_counters("collision");

        // Random mix, pool keys own distinct bank 1 buckets apart from slot 5
        for (int i = 0; i < POOL; i++) begin
            pool[i] = $urandom();
            pool[i][7:4] = (i < 5) ? 4'(i) : 4'(i + 1);
            pool[i][3:0] = 4'(i % 8);
        end
        for (int n = 0; n < N_MIX; n++) begin
            ins = ($urandom_range(0, 99) < 60);
            send_update(pool[$urandom_range(0, POOL - 1)], value_t'($urandom()), ins);
            idle_cycles(1);
            n_look = $urandom_range(1, 3);
            repeat (n_look) lookup(pool[$urandom_range(0, POOL - 1)], "random_mix");
        end
        wait_drain();
        check_counters("random_mix");

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        assert_fail = uut.u_assert.assert_errors;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, assert_fail);
        if ((n_errors == 0) && (assert_fail == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tb/htable_assert.sv
`timescale 1ns/1ns

`include "htable_defs.svh"

module htable_assert
    import htable_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   upd_valid,
    input logic   upd_ready,
    input key_t   upd_key,
    input value_t upd_value,
    input logic   upd_insert,
    input logic   query_valid,
    input logic   result_valid,
    input cnt_t   cnt_active
);

    localparam int MAX_ACTIVE = `HTABLE_NUM_TABLES * (1 << `HTABLE_HASH_WID);

    // Read by the testbench at the end of the run
    int assert_errors = 0;

    // Two register stages from query to result
    property p_result_latency;
        @(posedge clk) ($past(rst_n) && $past(rst_n, 2))
            |-> (result_valid == $past(query_valid, 2));
    endproperty

    // A stalled update holds its fields
    property p_upd_stable;
        @(posedge clk) disable iff (!rst_n)
            (upd_valid && !upd_ready)
            |=> (upd_valid && $stable(upd_key) && $stable(upd_value) && $stable(upd_insert));
    endproperty

    property p_reset_quiet;
        @(posedge clk) !rst_n |=> (!upd_ready && !result_valid);
    endproperty

    property p_active_bound;
        @(posedge clk) disable iff (!rst_n) cnt_active <= cnt_t'(MAX_ACTIVE);
    endproperty

    a_result_latency: assert property (p_result_latency)
        else begin
            assert_errors++;
            $error("result_valid does not follow query_valid by two cycles");
        end

    a_upd_stable: assert property (p_upd_stable)
        else begin
            assert_errors++;
            $error("update fields changed while the update was stalled");
        end

    a_reset_quiet: assert property (p_reset_quiet)
        else begin
            assert_errors++;
            $error("upd_ready or result_valid high during reset");
        end

    a_active_bound: assert property (p_active_bound)
        else begin
            assert_errors++;
            $error("cnt_active exceeds the number of buckets");
        end

endmodule

bind htable_top htable_assert u_assert (
    .clk, .rst_n, .upd_valid, .upd_ready, .upd_key, .upd_value, .upd_insert,
    .query_valid, .result_valid, .cnt_active
);

//--- verilog/htable_top.sv
`timescale 1ns/1ns

`include "htable_defs.svh"

module htable_top
    import htable_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   upd_valid,
    output logic   upd_ready,
    input  key_t   upd_key,
    input  value_t upd_value,
    input  logic   upd_insert,
    input  logic   query_valid,
    input  key_t   query_key,
    output logic   result_valid,
    output logic   result_found,
    output value_t result_value,
    output cnt_t   cnt_update,
    output cnt_t   cnt_insert_ok,
    output cnt_t   cnt_insert_fail,
    output cnt_t   cnt_delete_ok,
    output cnt_t   cnt_delete_fail,
    output cnt_t   cnt_active
);

    localparam int NUM = `HTABLE_NUM_TABLES;
    localparam int HW  = `HTABLE_HASH_WID;

    htable_upd_if upd_hashed ();
    htable_upd_if upd_pending ();

    key_t      search_key;
    logic      search_hit;
    logic      search_insert;
    value_t    search_value;

    // Engine on bank port A, lookup on port B
    hash_vec_t eng_rd_hash;
    hash_vec_t lk_rd_hash;
    key_t      eng_key   [NUM];
    value_t    eng_value [NUM];
    logic      eng_valid [NUM];
    key_t      lk_key    [NUM];
    value_t    lk_value  [NUM];
    logic      lk_valid  [NUM];

    logic [NUM-1:0] wr_en;
    hash_t          wr_hash;
    key_t           wr_key;
    value_t         wr_value;
    logic           wr_set;

    htable_hash_stage u_hash_stage (
        .clk, .rst_n, .upd_valid, .upd_key, .upd_value, .upd_insert, .upd_ready,
        .out (upd_hashed), .cnt_update
    );

    htable_update_queue u_queue (
        .clk, .rst_n, .in (upd_hashed), .out (upd_pending),
        .search_key, .search_hit, .search_insert, .search_value
    );

    htable_insert_engine u_engine (
        .clk, .rst_n, .in (upd_pending), .rd_hash (eng_rd_hash),
        .bank_key (eng_key), .bank_value (eng_value), .bank_valid (eng_valid),
        .wr_en, .wr_hash, .wr_key, .wr_value, .wr_set,
        .cnt_insert_ok, .cnt_insert_fail, .cnt_delete_ok, .cnt_delete_fail, .cnt_active
    );

    htable_lookup u_lookup (
        .clk, .rst_n, .query_valid, .query_key,
        .search_key, .search_hit, .search_insert, .search_value, .rd_hash (lk_rd_hash),
        .bank_key (lk_key), .bank_value (lk_value), .bank_valid (lk_valid),
        .result_valid, .result_found, .result_value
    );

    for (genvar i = 0; i < NUM; i++) begin : g_bank
        htable_bank u_bank (
            .clk, .rst_n, .wr_en (wr_en[i]), .wr_hash, .wr_key, .wr_value, .wr_set,
            .rd_a_hash (eng_rd_hash[i*HW +: HW]), .rd_a_key (eng_key[i]),
            .rd_a_value (eng_value[i]), .rd_a_valid (eng_valid[i]),
            .rd_b_hash (lk_rd_hash[i*HW +: HW]), .rd_b_key (lk_key[i]),
            .rd_b_value (lk_value[i]), .rd_b_valid (lk_valid[i])
        );
    end

endmodule

//--- verilog/htable_lookup.sv
`timescale 1ns/1ns

`include "htable_defs.svh"

module htable_lookup
    import htable_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      query_valid,
    input  key_t      query_key,
    output key_t      search_key,
    input  logic      search_hit,
    input  logic      search_insert,
    input  value_t    search_value,
    output hash_vec_t rd_hash,
    input  key_t      bank_key   [`HTABLE_NUM_TABLES],
    input  value_t    bank_value [`HTABLE_NUM_TABLES],
    input  logic      bank_valid [`HTABLE_NUM_TABLES],
    output logic      result_valid,
    output logic      result_found,
    output value_t    result_value
);

    logic   valid_s1;
    key_t   key_s1;
    logic   hit_s1;
    logic   insert_s1;
    value_t value_s1;
    logic   bank_found;
    value_t bank_val;

    // Stage one, queue search and bank read address
    assign search_key = query_key;
    assign rd_hash    = key_hashes(query_key);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s1     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            valid_s1     <= query_valid;
            result_valid <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        key_s1    <= query_key;
        hit_s1    <= search_hit;
        insert_s1 <= search_insert;
        value_s1  <= search_value;
    end

    // Stage two, lowest-numbered matching bank supplies the value
    always_comb begin
        bank_found = 1'b0;
        bank_val   = '0;
        for (int i = `HTABLE_NUM_TABLES - 1; i >= 0; i--) begin
            if (bank_valid[i] && (bank_key[i] == key_s1)) begin
                bank_found = 1'b1;
                bank_val   = bank_value[i];
            end
        end
    end

    // A pending update overrides whatever the banks hold
    always_ff @(posedge clk) begin
        if (hit_s1) begin
            result_found <= insert_s1;
            result_value <= insert_s1 ? value_s1 : '0;
        end else begin
            result_found <= bank_found;
            result_value <= bank_val;
        end
    end

endmodule

//--- verilog/htable_bank.sv
`timescale 1ns/1ns

module htable_bank
    import htable_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wr_en,
    input  hash_t  wr_hash,
    input  key_t   wr_key,
    input  value_t wr_value,
    input  logic   wr_set,
    input  hash_t  rd_a_hash,
    output key_t   rd_a_key,
    output value_t rd_a_value,
    output logic   rd_a_valid,
    input  hash_t  rd_b_hash,
    output key_t   rd_b_key,
    output value_t rd_b_value,
    output logic   rd_b_valid
);

    localparam int BUCKETS = 1 << $bits(hash_t);

    logic [BUCKETS-1:0] valid_q;
    key_t               key_mem   [BUCKETS];
    value_t             value_mem [BUCKETS];

    // Valid bits and registered read flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            rd_a_valid <= 1'b0;
            rd_b_valid <= 1'b0;
        end else begin
            if (wr_en) valid_q[wr_hash] <= wr_set;
            rd_a_valid <= valid_q[rd_a_hash];
            rd_b_valid <= valid_q[rd_b_hash];
        end
    end

    // Delete clears the valid bit only
    always_ff @(posedge clk) begin
        if (wr_en && wr_set) begin
            key_mem[wr_hash]   <= wr_key;
            value_mem[wr_hash] <= wr_value;
        end
        rd_a_key   <= key_mem[rd_a_hash];
        rd_a_value <= value_mem[rd_a_hash];
        rd_b_key   <= key_mem[rd_b_hash];
        rd_b_value <= value_mem[rd_b_hash];
    end

endmodule

//--- verilog/htable_insert_engine.sv
`timescale 1ns/1ns

`include "htable_defs.svh"

module htable_insert_engine
    import htable_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    htable_upd_if.sink in,
    output hash_vec_t rd_hash,
    input  key_t      bank_key   [`HTABLE_NUM_TABLES],
    input  value_t    bank_value [`HTABLE_NUM_TABLES],
    input  logic      bank_valid [`HTABLE_NUM_TABLES],
    output logic [`HTABLE_NUM_TABLES-1:0] wr_en,
    output hash_t     wr_hash,
    output key_t      wr_key,
    output value_t    wr_value,
    output logic      wr_set,
    output cnt_t      cnt_insert_ok,
    output cnt_t      cnt_insert_fail,
    output cnt_t      cnt_delete_ok,
    output cnt_t      cnt_delete_fail,
    output cnt_t      cnt_active
);

    localparam int NUM     = `HTABLE_NUM_TABLES;
    localparam int SEL_WID = $clog2(NUM);

    engine_state_t      state;
    logic [NUM-1:0]     match;
    logic [NUM-1:0]     free;
    logic               hit;
    logic               has_free;
    logic [SEL_WID-1:0] sel;
    logic               decide;

    // Head stays in the queue until DECIDE, so its fields are used directly
    assign rd_hash  = in.hashes;
    assign decide   = (state == DECIDE);
    assign in.ready = decide;

    // ==================================================================
    // Bucket selection
    // ==================================================================
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            match[i] = bank_valid[i] && (bank_key[i] == in.key);
            free[i]  = !bank_valid[i];
        end
        hit      = |match;
        has_free = |free;
        // Lowest-numbered matching bank, else lowest free one
        sel = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (hit ? match[i] : free[i]) sel = SEL_WID'(i);
        end
    end

    // A delete only ever touches a bucket holding its key
    assign wr_en    = (decide && (hit || (in.insert && has_free))) ? (NUM'(1) << sel) : '0;
    assign wr_hash  = in.hashes[sel*`HTABLE_HASH_WID +: `HTABLE_HASH_WID];
    assign wr_key   = in.key;
    assign wr_value = in.value;
    assign wr_set   = in.insert;

    // IDLE takes the head, READ waits on the bank read, DECIDE applies it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (in.valid) state <= READ;
                READ:    state <= DECIDE;
                default: state <= IDLE;
            endcase
        end
    end

    // ==================================================================
    // Statistics
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_insert_ok   <= '0;
            cnt_insert_fail <= '0;
            cnt_delete_ok   <= '0;
            cnt_delete_fail <= '0;
            cnt_active      <= '0;
        end else if (decide) begin
            if (in.insert) begin
                if (hit || has_free) cnt_insert_ok <= cnt_insert_ok + 1'b1;
                else cnt_insert_fail <= cnt_insert_fail + 1'b1;
                // Re-insert of a present key leaves active unchanged
                if (!hit && has_free) cnt_active <= cnt_active + 1'b1;
            end else if (hit) begin
                cnt_delete_ok <= cnt_delete_ok + 1'b1;
                cnt_active    <= cnt_active - 1'b1;
            end else begin
                cnt_delete_fail <= cnt_delete_fail + 1'b1;
            end
        end
    end

endmodule

//--- verilog/htable_update_queue.sv
`timescale 1ns/1ns

`include "htable_defs.svh"

module htable_update_queue
    import htable_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    htable_upd_if.sink   in,
    htable_upd_if.source out,
    input  key_t   search_key,
    output logic   search_hit,
    output logic   search_insert,
    output value_t search_value
);

    localparam int DEPTH   = `HTABLE_QUEUE_DEPTH;
    localparam int PTR_WID = $clog2(DEPTH);

    key_t      key_mem    [DEPTH];
    value_t    value_mem  [DEPTH];
    logic      insert_mem [DEPTH];
    hash_vec_t hashes_mem [DEPTH];

    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [PTR_WID:0]   count;
    logic               push;
    logic               pop;

    assign in.ready  = (count != (PTR_WID+1)'(DEPTH));
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;
    assign out.valid = (count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            key_mem[wr_ptr]    <= in.key;
            value_mem[wr_ptr]  <= in.value;
            insert_mem[wr_ptr] <= in.insert;
            hashes_mem[wr_ptr] <= in.hashes;
        end
    end

    // Head entry
    assign out.key    = key_mem[rd_ptr];
    assign out.value  = value_mem[rd_ptr];
    assign out.insert = insert_mem[rd_ptr];
    assign out.hashes = hashes_mem[rd_ptr];

    // ==================================================================
    // Key search, oldest to youngest so the newest match wins
    // ==================================================================
    always_comb begin
        logic [PTR_WID-1:0] idx;
        search_hit    = 1'b0;
        search_insert = 1'b0;
        search_value  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = rd_ptr + PTR_WID'(i);
            if (((PTR_WID+1)'(i) < count) && (key_mem[idx] == search_key)) begin
                search_hit    = 1'b1;
                search_insert = insert_mem[idx];
                search_value  = value_mem[idx];
            end
        end
    end

endmodule

//--- verilog/htable_hash_stage.sv
`timescale 1ns/1ns

module htable_hash_stage
    import htable_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   upd_valid,
    input  key_t   upd_key,
    input  value_t upd_value,
    input  logic   upd_insert,
    output logic   upd_ready,
    htable_upd_if.source out,
    output cnt_t   cnt_update
);

    logic      run;
    logic      full;
    logic      accept;
    key_t      key_q;
    value_t    value_q;
    logic      insert_q;
    hash_vec_t hashes_q;

    // Single holding register, drained in the same cycle it refills
    assign upd_ready = run && (!full || out.ready);
    assign accept    = upd_valid && upd_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run        <= 1'b0;
            full       <= 1'b0;
            cnt_update <= '0;
        end else begin
            // Ready stays low until the first cycle out of reset
            run <= 1'b1;
            if (accept) begin
                full       <= 1'b1;
                cnt_update <= cnt_update + 1'b1;
            end else if (out.ready) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            key_q    <= upd_key;
            value_q  <= upd_value;
            insert_q <= upd_insert;
            hashes_q <= key_hashes(upd_key);
        end
    end

    assign out.valid  = full;
    assign out.key    = key_q;
    assign out.value  = value_q;
    assign out.insert = insert_q;
    assign out.hashes = hashes_q;

endmodule

//--- verilog/htable_upd_if.sv
`timescale 1ns/1ns

// One hashed update, valid/ready handshake
interface htable_upd_if
    import htable_pkg::*;
();

    logic      valid;
    logic      ready;
    key_t      key;
    value_t    value;
    // 1 for insert, 0 for delete
    logic      insert;
    hash_vec_t hashes;

    modport source (
        output valid,
        output key,
        output value,
        output insert,
        output hashes,
        input  ready
    );

    modport sink (
        input  valid,
        input  key,
        input  value,
        input  insert,
        input  hashes,
        output ready
    );

endinterface

//--- verilog/htable_pkg.sv
package htable_pkg;

`include "htable_defs.svh"

    typedef logic [`HTABLE_KEY_WID-1:0]   key_t;
    typedef logic [`HTABLE_VALUE_WID-1:0] value_t;
    typedef logic [`HTABLE_HASH_WID-1:0]  hash_t;
    typedef logic [`HTABLE_CNT_WID-1:0]   cnt_t;

    // Bucket index for bank i sits at bits [4i +: 4]
    typedef logic [`HTABLE_NUM_TABLES*`HTABLE_HASH_WID-1:0] hash_vec_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DECIDE
    } engine_state_t;

    // Bank i indexes with key bits 4i through 4i+3
    function automatic hash_vec_t key_hashes(input key_t key);
        hash_vec_t h;
        for (int i = 0; i < `HTABLE_NUM_TABLES; i++) begin
            h[i*`HTABLE_HASH_WID +: `HTABLE_HASH_WID] =
                key[i*`HTABLE_HASH_WID +: `HTABLE_HASH_WID];
        end
        return h;
    endfunction

endpackage

//--- verilog/htable_defs.svh
`ifndef HTABLE_DEFS_SVH
`define HTABLE_DEFS_SVH

// ======================================================================
// Table geometry
// ======================================================================

// Key and stored value widths
`define HTABLE_KEY_WID     32
`define HTABLE_VALUE_WID   16

// Bucket index width, 16 buckets per bank
`define HTABLE_HASH_WID    4

// Number of hash banks
`define HTABLE_NUM_TABLES  3

// ======================================================================
// Update path and statistics
// ======================================================================

// Pending updates held ahead of the insertion engine
`define HTABLE_QUEUE_DEPTH 8

`define HTABLE_CNT_WID     32

`endif
